// ==== rtl/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// Byte address split as tag | index | offset
	localparam int addr_width = 16;
	localparam int data_width = 16; // One word

	localparam int offset_width = 3; // Byte within a 4-word block
	localparam int index_width = 5; // 32 sets
	localparam int tag_width = addr_width - index_width - offset_width;

	localparam int words_per_block = 4;

	// Main memory is word addressed behind the byte address
	localparam int mem_words = 32768;
	localparam int mem_read_latency = 2; // Cycles from mem_rd to data

endpackage

// ==== rtl/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

	// Consecutive codes so wb, req and fill steps advance by one
	typedef enum logic [3:0] {
		idle    = 4'd0,
		enable  = 4'd1,
		wb_0    = 4'd2,
		wb_1    = 4'd3,
		wb_2    = 4'd4,
		wb_3    = 4'd5,
		req_0   = 4'd6,
		req_1   = 4'd7,
		fill_0  = 4'd8,
		fill_1  = 4'd9,
		fill_2  = 4'd10,
		fill_3  = 4'd11,
		done_st = 4'd12
	} ctrl_state;

	typedef logic [1:0] way_sel; // One-hot, bit n enables way n

	localparam way_sel sel_none = 2'b00;
	localparam way_sel sel_way0 = 2'b01;
	localparam way_sel sel_way1 = 2'b10;
	localparam way_sel sel_both = 2'b11;

endpackage

// ==== rtl/cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   enable,
	input  logic [cache_geom_pkg::index_width-1:0]  index,
	input  logic [cache_geom_pkg::tag_width-1:0]    tag_in,
	input  logic [cache_geom_pkg::offset_width-1:0] offset,
	input  logic [cache_geom_pkg::data_width-1:0]   write_data,
	input  logic                                   comp,
	input  logic                                   write,
	input  logic                                   valid_in,
	output logic                                   hit,
	output logic                                   valid,
	output logic                                   dirty,
	output logic [cache_geom_pkg::tag_width-1:0]    tag_out,
	output logic [cache_geom_pkg::data_width-1:0]   read_data
);
	import cache_geom_pkg::*;

	logic [tag_width-1:0]         tag_mem [1 << index_width];
	logic [(1 << index_width)-1:0] valid_bits;
	logic [(1 << index_width)-1:0] dirty_bits;
	logic [data_width-1:0]        data_mem [(1 << index_width) * words_per_block];

	logic [index_width+offset_width-2:0] word_addr;
	logic                                tag_match;
	logic                                store;

	assign word_addr = {index, offset[offset_width-1:1]}; // Set and word within block

	// Lookup side is purely combinational
	assign tag_out   = tag_mem[index];
	assign valid     = valid_bits[index];
	assign dirty     = dirty_bits[index];
	assign read_data = data_mem[word_addr];
	assign tag_match = (tag_out == tag_in);
	assign hit       = enable & valid & tag_match;

	// Compare mode only writes on a hit, access mode writes blindly
	assign store = enable & write & (~comp | hit);

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (store) begin
			if (comp) begin
				dirty_bits[index] <= 1'b1; // Write hit
			end else begin
				valid_bits[index] <= valid_in; // Refill of a block
				dirty_bits[index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (store) begin
			data_mem[word_addr] <= write_data;
		end
		if (store && !comp) begin
			tag_mem[index] <= tag_in; // New owner of the set entry
		end
	end

endmodule

// ==== rtl/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [cache_geom_pkg::addr_width-1:0]   addr,
	input  logic [cache_geom_pkg::data_width-1:0]   data_in,
	input  logic                                   rd,
	input  logic                                   wr,
	input  logic [1:0]                             way_hit,
	input  logic [1:0]                             way_valid,
	input  logic [1:0]                             way_dirty,
	input  logic [cache_geom_pkg::tag_width-1:0]    way0_tag,
	input  logic [cache_geom_pkg::tag_width-1:0]    way1_tag,
	input  logic [cache_geom_pkg::data_width-1:0]   way0_data,
	input  logic [cache_geom_pkg::data_width-1:0]   way1_data,
	input  logic [cache_geom_pkg::data_width-1:0]   mem_read_data,
	output logic [cache_geom_pkg::data_width-1:0]   data_out,
	output logic                                   done,
	output logic                                   stall,
	output logic                                   cache_hit,
	output logic                                   err,
	output cache_ctrl_pkg::way_sel                 cache_enable,
	output logic [cache_geom_pkg::index_width-1:0]  cache_index,
	output logic [cache_geom_pkg::tag_width-1:0]    cache_tag,
	output logic [cache_geom_pkg::offset_width-1:0] cache_offset,
	output logic [cache_geom_pkg::data_width-1:0]   cache_write_data,
	output logic                                   comp,
	output logic                                   write,
	output logic                                   valid_in,
	output logic [cache_geom_pkg::addr_width-1:0]   mem_addr,
	output logic [cache_geom_pkg::data_width-1:0]   mem_write_data,
	output logic                                   mem_wr,
	output logic                                   mem_rd
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	ctrl_state state;
	ctrl_state next_state;

	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_data;
	logic                  req_wr;
	logic                  victim_ptr; // Next way to replace when both are valid
	way_sel                way_q; // Way being refilled

	logic [index_width-1:0] req_index;
	logic [tag_width-1:0]   req_tag;
	way_sel                 victim_sel;
	logic                   victim_dirty;
	logic [tag_width-1:0]   victim_tag;
	logic [data_width-1:0]  victim_data;
	logic                   strobe;
	logic                   misaligned;
	logic                   hit_any;
	logic [1:0]             wb_word;
	logic [1:0]             req_word;
	logic [1:0]             fill_word;

	assign req_index = req_addr[offset_width +: index_width];
	assign req_tag   = req_addr[addr_width-1 -: tag_width];

	assign strobe     = rd | wr;
	assign misaligned = addr[0];
	assign hit_any    = |way_hit;

	// Invalid way first, then round robin
	always_comb begin
		if (!way_valid[0]) begin
			victim_sel = sel_way0;
		end else if (!way_valid[1]) begin
			victim_sel = sel_way1;
		end else if (victim_ptr) begin
			victim_sel = sel_way1;
		end else begin
			victim_sel = sel_way0;
		end
	end

	assign victim_dirty = |(victim_sel & way_valid & way_dirty);
	assign victim_tag   = way_q[1] ? way1_tag : way0_tag;
	assign victim_data  = way_q[1] ? way1_data : way0_data;

	assign data_out = way_hit[1] ? way1_data : (way_hit[0] ? way0_data : victim_data);

	// Word number inside the current step group
	assign wb_word   = 2'(state - wb_0);
	assign req_word  = 2'(state - req_0);
	assign fill_word = 2'(state - fill_0);

	always_comb begin
		next_state       = state;
		done             = 1'b0;
		stall            = 1'b1; // Held through the whole miss
		cache_hit        = 1'b0;
		err              = 1'b0;
		cache_enable     = sel_none;
		cache_index      = req_index;
		cache_tag        = req_tag;
		cache_offset     = req_addr[offset_width-1:0];
		cache_write_data = req_data;
		comp             = 1'b0;
		write            = 1'b0;
		valid_in         = 1'b0;
		mem_addr         = {req_tag, req_index, req_word, 1'b0};
		mem_write_data   = victim_data;
		mem_wr           = 1'b0;
		mem_rd           = 1'b0;
		case (state)
			idle: begin
				cache_index      = addr[offset_width +: index_width];
				cache_tag        = addr[addr_width-1 -: tag_width];
				cache_offset     = addr[offset_width-1:0];
				cache_write_data = data_in;
				comp             = 1'b1;
				write            = wr & ~misaligned;
				cache_enable     = (strobe && !misaligned) ? sel_both : sel_none;
				done             = strobe & (misaligned | hit_any);
				err              = strobe & misaligned;
				cache_hit        = strobe & ~misaligned & hit_any;
				stall            = strobe & ~misaligned & ~hit_any;
				if (stall) begin
					next_state = enable;
				end
			end
			enable: begin
				cache_enable = victim_sel;
				next_state   = victim_dirty ? wb_0 : req_0;
			end
			wb_0, wb_1, wb_2, wb_3: begin // Victim word out to memory
				cache_enable = way_q;
				cache_tag    = victim_tag;
				cache_offset = {wb_word, 1'b0};
				mem_addr     = {victim_tag, req_index, wb_word, 1'b0};
				mem_wr       = 1'b1;
				next_state   = ctrl_state'(state + 4'd1);
			end
			req_0, req_1: begin
				mem_rd     = 1'b1;
				next_state = ctrl_state'(state + 4'd1);
			end
			fill_0, fill_1, fill_2, fill_3: begin
				cache_enable     = way_q;
				cache_offset     = {fill_word, 1'b0};
				cache_write_data = mem_read_data;
				write            = 1'b1;
				valid_in         = 1'b1;
				if (!fill_word[1]) begin // Words 2 and 3 requested under the fill
					mem_rd   = 1'b1;
					mem_addr = {req_tag, req_index, fill_word + 2'd2, 1'b0};
				end
				next_state = ctrl_state'(state + 4'd1);
			end
			done_st: begin
				cache_enable = way_q;
				comp         = 1'b1;
				write        = req_wr;
				done         = 1'b1;
				stall        = 1'b0;
				next_state   = idle;
			end
			default: begin
				stall      = 1'b0;
				next_state = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= idle;
			req_wr     <= 1'b0;
			victim_ptr <= 1'b0;
			way_q      <= sel_none;
		end else begin
			state <= next_state;
			if (state == idle) begin
				req_wr <= wr;
			end
			if (state == enable) begin
				way_q <= victim_sel;
				if (&way_valid) begin
					victim_ptr <= ~victim_ptr; // A valid block gets replaced
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle) begin
			req_addr <= addr;
			req_data <= data_in;
		end
	end

endmodule

// ==== rtl/four_bank_mem.sv ====
`timescale 1ns/1ps

module four_bank_mem (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [cache_geom_pkg::addr_width-1:0] mem_addr,
	input  logic [cache_geom_pkg::data_width-1:0] mem_write_data,
	input  logic                                 mem_wr,
	input  logic                                 mem_rd,
	output logic [cache_geom_pkg::data_width-1:0] mem_read_data
);
	import cache_geom_pkg::*;

	logic [data_width-1:0] banks [4][mem_words / 4];

	logic [1:0]              bank_sel;
	logic [addr_width-4:0]   row;
	logic [data_width-1:0]   bank_q [4];
	logic [1:0]              sel_q;
	logic [mem_read_latency-2:0] rd_vld;
	logic [data_width-1:0]   data_pipe [mem_read_latency - 1];

	// Bank picked by the two low bits of word address mem_addr[15:1]
	assign bank_sel = mem_addr[2:1];
	assign row      = mem_addr[addr_width-1:3];

	initial begin
		for (int b = 0; b < 4; b++) begin
			for (int r = 0; r < mem_words / 4; r++) begin
				banks[b][r] = 16'(r * 4 + b) ^ 16'h5a5a; // Word address XOR pattern
			end
		end
	end

	always @(posedge clk) begin
		if (mem_wr) begin
			banks[bank_sel][row] <= mem_write_data;
		end
	end

	// All banks read the row in parallel in stage 1
	always_ff @(posedge clk) begin
		if (mem_rd) begin
			for (int b = 0; b < 4; b++) begin
				bank_q[b] <= banks[b][row];
			end
			sel_q <= bank_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_vld <= '0;
		end else begin
			rd_vld[0] <= mem_rd;
			for (int i = 1; i < mem_read_latency - 1; i++) begin
				rd_vld[i] <= rd_vld[i-1];
			end
		end
	end

	// Bank mux then delay to the fixed latency
	always_ff @(posedge clk) begin
		if (rd_vld[0]) begin
			data_pipe[0] <= bank_q[sel_q];
		end
		for (int i = 1; i < mem_read_latency - 1; i++) begin
			if (rd_vld[i]) begin
				data_pipe[i] <= data_pipe[i-1];
			end
		end
	end

	assign mem_read_data = data_pipe[mem_read_latency-2];

endmodule

// ==== rtl/mem_system.sv ====
`timescale 1ns/1ps

module mem_system (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [cache_geom_pkg::addr_width-1:0] addr,
	input  logic [cache_geom_pkg::data_width-1:0] data_in,
	input  logic                                 rd,
	input  logic                                 wr,
	output logic [cache_geom_pkg::data_width-1:0] data_out,
	output logic                                 done,
	output logic                                 stall,
	output logic                                 cache_hit,
	output logic                                 err
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	logic [1:0]              way_hit;
	logic [1:0]              way_valid;
	logic [1:0]              way_dirty;
	logic [tag_width-1:0]    way0_tag;
	logic [tag_width-1:0]    way1_tag;
	logic [data_width-1:0]   way0_data;
	logic [data_width-1:0]   way1_data;
	way_sel                  cache_enable;
	logic [index_width-1:0]  cache_index;
	logic [tag_width-1:0]    cache_tag;
	logic [offset_width-1:0] cache_offset;
	logic [data_width-1:0]   cache_write_data;
	logic                    comp;
	logic                    write;
	logic                    valid_in;
	logic [addr_width-1:0]   mem_addr;
	logic [data_width-1:0]   mem_write_data;
	logic                    mem_wr;
	logic                    mem_rd;
	logic [data_width-1:0]   mem_read_data;

	cache_way u_way0 (
		.clk(clk), .reset(reset), .enable(cache_enable[0]),
		.index(cache_index), .tag_in(cache_tag), .offset(cache_offset),
		.write_data(cache_write_data), .comp(comp), .write(write), .valid_in(valid_in),
		.hit(way_hit[0]), .valid(way_valid[0]), .dirty(way_dirty[0]),
		.tag_out(way0_tag), .read_data(way0_data)
	);

	cache_way u_way1 (
		.clk(clk), .reset(reset), .enable(cache_enable[1]),
		.index(cache_index), .tag_in(cache_tag), .offset(cache_offset),
		.write_data(cache_write_data), .comp(comp), .write(write), .valid_in(valid_in),
		.hit(way_hit[1]), .valid(way_valid[1]), .dirty(way_dirty[1]),
		.tag_out(way1_tag), .read_data(way1_data)
	);

	cache_controller u_ctrl (
		.clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.way_hit(way_hit), .way_valid(way_valid), .way_dirty(way_dirty),
		.way0_tag(way0_tag), .way1_tag(way1_tag),
		.way0_data(way0_data), .way1_data(way1_data), .mem_read_data(mem_read_data),
		.data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err),
		.cache_enable(cache_enable), .cache_index(cache_index), .cache_tag(cache_tag),
		.cache_offset(cache_offset), .cache_write_data(cache_write_data),
		.comp(comp), .write(write), .valid_in(valid_in),
		.mem_addr(mem_addr), .mem_write_data(mem_write_data), .mem_wr(mem_wr), .mem_rd(mem_rd)
	);

	four_bank_mem u_mem (
		.clk(clk), .reset(reset), .mem_addr(mem_addr), .mem_write_data(mem_write_data),
		.mem_wr(mem_wr), .mem_rd(mem_rd), .mem_read_data(mem_read_data)
	);

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset
);
	localparam int half_period = 10; // 20 ns period
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever begin
			#half_period clk = ~clk;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0; // Released just after the edge
	end

endmodule

// ==== testbench/mem_system_tb.sv ====
`timescale 1ns/1ps

module mem_system_tb;
	import cache_geom_pkg::*;

	localparam int timeout_cycles = 40;
	localparam int num_sets = 1 << index_width;
	localparam logic [31:0] seed = 32'h4a47_8538;

	logic                  clk;
	logic                  reset;
	logic [addr_width-1:0] addr;
	logic [data_width-1:0] data_in;
	logic                  rd;
	logic                  wr;
	logic [data_width-1:0] data_out;
	logic                  done;
	logic                  stall;
	logic                  cache_hit;
	logic                  err;

	// Requester view of memory plus the cache bookkeeping
	logic [data_width-1:0] ref_mem [mem_words];
	logic [tag_width-1:0]  shadow_tag [num_sets][2];
	logic                  shadow_valid [num_sets][2];
	logic                  shadow_dirty [num_sets][2];
	logic                  shadow_ptr; // One pointer shared by all sets

	int error_count;
	int check_count;

	clock_gen u_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	mem_system u_mem_system (
		.clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
	);

	function automatic void reset_model();
		int w;
		int s;
		for (w = 0; w < mem_words; w++) begin
			ref_mem[w] = 16'(w) ^ 16'h5a5a; // Initial memory rule
		end
		for (s = 0; s < num_sets; s++) begin
			for (w = 0; w < 2; w++) begin
				shadow_tag[s][w] = '0;
				shadow_valid[s][w] = 1'b0;
				shadow_dirty[s][w] = 1'b0;
			end
		end
		shadow_ptr = 1'b0;
	endfunction

	// Expected read value, hit flag and latency, and updates the model
	function automatic void predict_access(
		input  logic                  is_wr,
		input  logic [addr_width-1:0] a,
		input  logic [data_width-1:0] d,
		output logic [data_width-1:0] exp_data,
		output logic                  exp_hit,
		output int                    exp_lat
	);
		logic [index_width-1:0] set_idx;
		logic [tag_width-1:0]   tag;
		int                     word_addr;
		int                     w;
		int                     way;
		set_idx = a[offset_width +: index_width];
		tag = a[addr_width-1 -: tag_width];
		word_addr = int'(a[addr_width-1:1]);
		way = -1;
		for (w = 0; w < 2; w++) begin
			if (shadow_valid[set_idx][w] && shadow_tag[set_idx][w] == tag) begin
				way = w;
			end
		end
		exp_hit = (way >= 0);
		exp_lat = 0;
		if (!exp_hit) begin
			if (!shadow_valid[set_idx][0]) begin
				way = 0;
			end else if (!shadow_valid[set_idx][1]) begin
				way = 1;
			end else begin
				way = int'(shadow_ptr);
				shadow_ptr = ~shadow_ptr; // Flips only when a valid block goes
			end
			exp_lat = (shadow_valid[set_idx][way] && shadow_dirty[set_idx][way]) ? 12 : 8;
			shadow_tag[set_idx][way] = tag;
			shadow_valid[set_idx][way] = 1'b1;
			shadow_dirty[set_idx][way] = 1'b0;
		end
		if (is_wr) begin
			shadow_dirty[set_idx][way] = 1'b1;
			ref_mem[word_addr] = d;
		end
		exp_data = ref_mem[word_addr];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] time %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// One strobe, then wait for done
	task automatic issue_access(
		input  logic                  is_wr,
		input  logic [addr_width-1:0] a,
		input  logic [data_width-1:0] d,
		output logic [data_width-1:0] got_data,
		output logic                  got_hit,
		output logic                  got_err,
		output logic                  got_stall,
		output int                    got_lat,
		output logic                  timed_out
	);
		int cyc;
		@(posedge clk);
		#1;
		addr = a;
		data_in = d;
		rd = ~is_wr;
		wr = is_wr;
		@(negedge clk);
		got_stall = stall;
		cyc = 0;
		while (!done && cyc < timeout_cycles) begin
			@(posedge clk);
			#1;
			rd = 1'b0;
			wr = 1'b0;
			@(negedge clk);
			cyc++;
		end
		timed_out = !done;
		got_data = data_out;
		got_hit = cache_hit;
		got_err = err;
		got_lat = cyc;
		@(posedge clk);
		#1;
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic run_checked_access(input logic is_wr, input logic [addr_width-1:0] a,
		input logic [data_width-1:0] d);
		logic [data_width-1:0] exp_data;
		logic                  exp_hit;
		int                    exp_lat;
		logic [data_width-1:0] got_data;
		logic                  got_hit;
		logic                  got_err;
		logic                  got_stall;
		int                    got_lat;
		logic                  timed_out;
		predict_access(is_wr, a, d, exp_data, exp_hit, exp_lat);
		issue_access(is_wr, a, d, got_data, got_hit, got_err, got_stall, got_lat, timed_out);
		if (timed_out) begin
			error_count++;
			$display("Time %0t: done never came within %0d cycles for address %h",
				$time, timeout_cycles, a);
		end else begin
			compare_value("cache_hit", 32'(got_hit), 32'(exp_hit));
			compare_value("done latency", got_lat, exp_lat);
			compare_value("stall", 32'(got_stall), 32'(exp_lat != 0));
			compare_value("err", 32'(got_err), 32'd0);
			if (!is_wr) begin
				compare_value("data_out", 32'(got_data), 32'(exp_data));
			end
		end
	endtask

	// Odd address leaves the model untouched
	task automatic run_misaligned(input logic is_wr, input logic [addr_width-1:0] a,
		input logic [data_width-1:0] d);
		logic [data_width-1:0] got_data;
		logic                  got_hit;
		logic                  got_err;
		logic                  got_stall;
		int                    got_lat;
		logic                  timed_out;
		issue_access(is_wr, a, d, got_data, got_hit, got_err, got_stall, got_lat, timed_out);
		if (timed_out) begin
			error_count++;
			$display("Time %0t: misaligned access to %h never raised done", $time, a);
		end else begin
			compare_value("err", 32'(got_err), 32'd1);
			compare_value("stall", 32'(got_stall), 32'd0);
			compare_value("cache_hit", 32'(got_hit), 32'd0);
			compare_value("done latency", got_lat, 0);
		end
	endtask

	task automatic wait_for_reset();
		int cyc;
		cyc = 0;
		@(posedge clk);
		while (reset && cyc < timeout_cycles) begin
			@(posedge clk);
			cyc++;
		end
		if (reset) begin
			error_count++;
			$display("Reset was still asserted after %0d cycles", timeout_cycles);
		end
		@(negedge clk);
		compare_value("done", 32'(done), 32'd0);
		compare_value("stall", 32'(stall), 32'd0);
		compare_value("err", 32'(err), 32'd0);
		compare_value("cache_hit", 32'(cache_hit), 32'd0);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d mismatches", name, error_count - errors_before);
		end
	endtask

	initial begin
		int                    errs_before;
		int                    i;
		logic [addr_width-1:0] a;
		logic                  is_wr;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		error_count = 0;
		check_count = 0;
		void'($urandom(seed));
		reset_model();
		wait_for_reset();

		errs_before = error_count;
		for (i = 0; i < 4; i++) begin
			a = {8'h01, 5'(i * 7), 2'(i), 1'b0}; // Sets 0, 7, 14, 21
			run_checked_access(1'b0, a, '0);
			run_checked_access(1'b0, a, '0);
		end
		finish_test("cold reads", errs_before);

		errs_before = error_count;
		run_checked_access(1'b0, 16'h0214, '0);
		run_checked_access(1'b1, 16'h0214, 16'hbeef); // Write hit
		run_checked_access(1'b0, 16'h0214, '0);
		run_checked_access(1'b1, 16'h4062, 16'h1234); // Write miss allocates
		run_checked_access(1'b0, 16'h4062, '0);
		run_checked_access(1'b0, 16'h4060, '0);
		finish_test("write hit and miss", errs_before);

		errs_before = error_count;
		run_checked_access(1'b1, 16'h102a, 16'haaa1);
		run_checked_access(1'b1, 16'h202a, 16'haaa2);
		run_checked_access(1'b0, 16'h302a, '0); // Dirty eviction
		run_checked_access(1'b0, 16'h102a, '0);
		run_checked_access(1'b0, 16'h202a, '0);
		finish_test("dirty eviction", errs_before);

		errs_before = error_count;
		run_checked_access(1'b0, 16'h5048, '0);
		run_checked_access(1'b0, 16'h5148, '0);
		run_checked_access(1'b0, 16'h5048, '0);
		run_checked_access(1'b0, 16'h5248, '0);
		run_checked_access(1'b0, 16'h5148, '0);
		run_checked_access(1'b0, 16'h5048, '0);
		run_checked_access(1'b0, 16'h5348, '0);
		run_checked_access(1'b0, 16'h5248, '0);
		finish_test("victim choice", errs_before);

		errs_before = error_count;
		run_misaligned(1'b1, 16'h0101, 16'hdead);
		run_misaligned(1'b0, 16'h0101, '0);
		run_checked_access(1'b0, 16'h0100, '0);
		finish_test("misaligned", errs_before);

		errs_before = error_count;
		for (i = 0; i < 200; i++) begin
			is_wr = 1'($urandom_range(0, 1));
			a = {6'b110000, 2'($urandom_range(0, 3)), 2'b10, 3'($urandom_range(0, 7)),
				2'($urandom_range(0, 3)), 1'b0};
			run_checked_access(is_wr, a, 16'($urandom));
		end
		finish_test("random traffic", errs_before);

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_way.sv
rtl/cache_controller.sv
rtl/four_bank_mem.sv
rtl/mem_system.sv
testbench/clock_gen.sv
testbench/mem_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f filelist.f --top-module mem_system_tb \
	-o sim_mem_system
./obj_dir/sim_mem_system | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"
